//--- wbdec_pkg.sv
////////////////////////////////////////////////////////////
// Shared bus widths, width types and router states for the
// request side of the single-master decode subsystem
////////////////////////////////////////////////////////////
package wbdec_pkg;

	////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////

	// Byte address width
	localparam int ADDR_W = 32;

	// Data word width
	localparam int DATA_W = 32;

	// One select bit per data byte
	localparam int SEL_W = DATA_W / 8;

	////////////////////////////////////////////////////////
	// Width types
	////////////////////////////////////////////////////////

	// Bus address
	typedef logic [ADDR_W-1:0] addr_t;

	// Bus data word, read or write
	typedef logic [DATA_W-1:0] data_t;

	// Byte enables
	typedef logic [SEL_W-1:0] sel_t;

	////////////////////////////////////////////////////////
	// Router FSM
	////////////////////////////////////////////////////////

	// One transaction outstanding at slave level at most
	typedef enum logic [1:0]
	{
		// Nothing outstanding, ready to accept
		RTR_IDLE = 2'd0,
		// Slave strobed, waiting on its acknowledge
		RTR_WAIT = 2'd1,
		// Unmapped address, bus error on the way out
		RTR_ERR  = 2'd2
	} rtr_state_t;

endpackage

//--- wb_skid.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Skid buffer between the master and the address decoder
// Registers the stall to the master and holds one request
////////////////////////////////////////////////////////////
module wb_skid
(
	input	logic			i_clk,
	input	logic			i_reset,
	// Master request
	input	logic			i_stb,
	input	logic			i_we,
	input	wbdec_pkg::addr_t	i_addr,
	input	wbdec_pkg::data_t	i_data,
	input	wbdec_pkg::sel_t	i_sel,
	output	logic			o_stall,
	// Toward the decoder
	output	logic			o_valid,
	output	logic			o_we,
	output	wbdec_pkg::addr_t	o_addr,
	output	wbdec_pkg::data_t	o_data,
	output	wbdec_pkg::sel_t	o_sel,
	input	logic			i_stall
);

	// Holding register, full while r_valid is set
	logic			r_valid;
	logic			r_we;
	wbdec_pkg::addr_t	r_addr;
	wbdec_pkg::data_t	r_data;
	wbdec_pkg::sel_t	r_sel;

	////////////////////////////////////////////////////////
	// Buffer control
	////////////////////////////////////////////////////////

	// Master only sees a registered stall
	assign o_stall = r_valid;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_valid <= 1'b0;
		// Passing request blocked downstream, keep it
		else if (i_stb && !r_valid && i_stall)
			r_valid <= 1'b1;
		// Held request taken by the decoder
		else if (!i_stall)
			r_valid <= 1'b0;
	end

	// Payload tracks the master while the buffer is empty
	always_ff @(posedge i_clk)
	begin
		if (!r_valid)
		begin
			r_we   <= i_we;
			r_addr <= i_addr;
			r_data <= i_data;
			r_sel  <= i_sel;
		end
	end

	////////////////////////////////////////////////////////
	// Output select
	////////////////////////////////////////////////////////

	// Held request goes first, else the live one flows through
	assign o_valid = r_valid || i_stb;
	assign o_we    = r_valid ? r_we   : i_we;
	assign o_addr  = r_valid ? r_addr : i_addr;
	assign o_data  = r_valid ? r_data : i_data;
	assign o_sel   = r_valid ? r_sel  : i_sel;

endmodule

//--- addrdecode.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Address decoder, one-hot slave select with a no-slave bit
// Base and mask per slave, output register optional
////////////////////////////////////////////////////////////
module addrdecode
#(
	parameter int NS = 1,
	parameter logic [NS*wbdec_pkg::ADDR_W-1:0] SLAVE_ADDR = '0,
	parameter logic [NS*wbdec_pkg::ADDR_W-1:0] SLAVE_MASK = '0,
	parameter bit OPT_REGISTERED = 1'b0
)
(
	input	logic			i_clk,
	input	logic			i_reset,
	// Request from the skid buffer
	input	logic			i_valid,
	input	logic			i_we,
	input	wbdec_pkg::addr_t	i_addr,
	input	wbdec_pkg::data_t	i_data,
	input	wbdec_pkg::sel_t	i_sel,
	output	logic			o_stall,
	// Decoded request toward the router
	output	logic			o_valid,
	output	logic	[NS:0]		o_decode,
	output	logic			o_we,
	output	wbdec_pkg::addr_t	o_addr,
	output	wbdec_pkg::data_t	o_data,
	output	wbdec_pkg::sel_t	o_sel,
	input	logic			i_stall
);

	localparam int AW = wbdec_pkg::ADDR_W;

	// Raw match per slave, not yet qualified by valid
	logic	[NS-1:0]	hit;
	// Qualified one-hot decode, top bit for no owner
	logic	[NS:0]		request;

	////////////////////////////////////////////////////////
	// Base and mask compare
	////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < NS; i++)
		begin
			// Only the bits under the mask must agree with the base
			hit[i] = (((i_addr ^ SLAVE_ADDR[i*AW +: AW])
				& SLAVE_MASK[i*AW +: AW]) == '0);
		end
	end

	// Nothing decoded without a request
	assign request = i_valid ? {~|hit, hit} : '0;

	////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////

	generate
		if (OPT_REGISTERED)
		begin : g_reg
			// Full and blocked downstream
			assign o_stall = o_valid && i_stall;

			always_ff @(posedge i_clk)
			begin
				if (i_reset)
				begin
					o_valid  <= 1'b0;
					o_decode <= '0;
				end
				else if (!o_stall)
				begin
					o_valid  <= i_valid;
					o_decode <= request;
				end
			end

			// Payload moves with the decode, held while stalled
			always_ff @(posedge i_clk)
			begin
				if (!o_stall)
				begin
					o_we   <= i_we;
					o_addr <= i_addr;
					o_data <= i_data;
					o_sel  <= i_sel;
				end
			end
		end
		else
		begin : g_comb
			// Decode in the same cycle, stall straight back
			assign o_stall  = i_stall;
			assign o_valid  = i_valid;
			assign o_decode = request;
			assign o_we     = i_we;
			assign o_addr   = i_addr;
			assign o_data   = i_data;
			assign o_sel    = i_sel;
		end
	endgenerate

endmodule

//--- wb_slave_router.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Router from the decoder to the slaves, one transaction at
// a time, with the bus error for unmapped addresses
////////////////////////////////////////////////////////////
module wb_slave_router
#(
	parameter int NS = 1
)
(
	input	logic				i_clk,
	input	logic				i_reset,
	// Decoded request
	input	logic				i_valid,
	input	logic	[NS:0]			i_decode,
	input	logic				i_we,
	input	wbdec_pkg::addr_t		i_addr,
	input	wbdec_pkg::data_t		i_data,
	input	wbdec_pkg::sel_t		i_sel,
	output	logic				o_stall,
	// Slave side, strobe per slave, rest shared
	output	logic	[NS-1:0]		o_slv_stb,
	output	logic				o_slv_we,
	output	wbdec_pkg::addr_t		o_slv_addr,
	output	wbdec_pkg::data_t		o_slv_data,
	output	wbdec_pkg::sel_t		o_slv_sel,
	input	logic	[NS-1:0]		i_slv_ack,
	input	wbdec_pkg::data_t [NS-1:0]	i_slv_rdata,
	// Response to the master
	output	logic				o_ack,
	output	logic				o_err,
	output	wbdec_pkg::data_t		o_rdata
);

	localparam int IW = (NS > 1) ? $clog2(NS) : 1;

	wbdec_pkg::rtr_state_t	state;
	// Index of the slave that was strobed
	logic	[IW-1:0]	slv_idx;
	// Index of the slave named by the incoming decode
	logic	[IW-1:0]	req_idx;
	logic			accept;

	// New work only when nothing is outstanding
	assign accept  = i_valid && (state == wbdec_pkg::RTR_IDLE);
	assign o_stall = (state != wbdec_pkg::RTR_IDLE);

	// One-hot to binary
	always_comb
	begin
		req_idx = '0;
		for (int i = 0; i < NS; i++)
		begin
			if (i_decode[i])
				req_idx = IW'(i);
		end
	end

	////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state     <= wbdec_pkg::RTR_IDLE;
			o_slv_stb <= '0;
			o_ack     <= 1'b0;
			o_err     <= 1'b0;
		end
		else
		begin
			// Strobe and responses are single-cycle pulses
			o_slv_stb <= '0;
			o_ack     <= 1'b0;
			o_err     <= 1'b0;
			case (state)
			wbdec_pkg::RTR_IDLE:
				if (accept && i_decode[NS])
				begin
					// No owner, answer with the error ourselves
					state <= wbdec_pkg::RTR_ERR;
					o_err <= 1'b1;
				end
				else if (accept)
				begin
					state     <= wbdec_pkg::RTR_WAIT;
					o_slv_stb <= i_decode[NS-1:0];
				end
			wbdec_pkg::RTR_WAIT:
				// Only the strobed slave can end the wait
				if (i_slv_ack[slv_idx])
				begin
					state <= wbdec_pkg::RTR_IDLE;
					o_ack <= 1'b1;
				end
			wbdec_pkg::RTR_ERR:
				state <= wbdec_pkg::RTR_IDLE;
			default:
				state <= wbdec_pkg::RTR_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////
	// Payload
	////////////////////////////////////////////////////////

	// Capture the request for the slave on acceptance
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			slv_idx    <= req_idx;
			o_slv_we   <= i_we;
			o_slv_addr <= i_addr;
			o_slv_data <= i_data;
			o_slv_sel  <= i_sel;
		end
	end

	// Read data returned alongside o_ack
	always_ff @(posedge i_clk)
	begin
		if ((state == wbdec_pkg::RTR_WAIT) && i_slv_ack[slv_idx])
			o_rdata <= i_slv_rdata[slv_idx];
	end

endmodule

//--- wb_decode_top.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Request side of the interconnect, skid to decoder to router
// The slave map is set here and passed down
////////////////////////////////////////////////////////////
module wb_decode_top
#(
	parameter int NS = 4,
	// Slave 3 in the top word, slave 0 in the bottom
	parameter logic [NS*wbdec_pkg::ADDR_W-1:0] SLAVE_ADDR = {
		32'h8000_0000, 32'h4000_0000, 32'h1000_0000, 32'h0000_0000 },
	parameter logic [NS*wbdec_pkg::ADDR_W-1:0] SLAVE_MASK = {
		32'hC000_0000, 32'hC000_0000, 32'hF000_0000, 32'hF000_0000 },
	parameter bit OPT_REGISTERED = 1'b1
)
(
	input	logic				i_clk,
	input	logic				i_reset,
	// Master request
	input	logic				i_stb,
	input	logic				i_we,
	input	wbdec_pkg::addr_t		i_addr,
	input	wbdec_pkg::data_t		i_data,
	input	wbdec_pkg::sel_t		i_sel,
	output	logic				o_stall,
	// Slaves
	output	logic	[NS-1:0]		o_slv_stb,
	output	logic				o_slv_we,
	output	wbdec_pkg::addr_t		o_slv_addr,
	output	wbdec_pkg::data_t		o_slv_data,
	output	wbdec_pkg::sel_t		o_slv_sel,
	input	logic	[NS-1:0]		i_slv_ack,
	input	wbdec_pkg::data_t [NS-1:0]	i_slv_rdata,
	// Master response
	output	logic				o_ack,
	output	logic				o_err,
	output	wbdec_pkg::data_t		o_rdata
);

	// Skid to decoder
	logic			skid_valid, skid_we;
	wbdec_pkg::addr_t	skid_addr;
	wbdec_pkg::data_t	skid_data;
	wbdec_pkg::sel_t	skid_sel;
	logic			dec_stall;

	// Decoder to router
	logic			dec_valid, dec_we;
	logic	[NS:0]		dec_decode;
	wbdec_pkg::addr_t	dec_addr;
	wbdec_pkg::data_t	dec_data;
	wbdec_pkg::sel_t	dec_sel;
	logic			rtr_stall;

	wb_skid u_skid (.i_clk, .i_reset, .i_stb, .i_we, .i_addr, .i_data, .i_sel,
		.o_stall, .o_valid(skid_valid), .o_we(skid_we), .o_addr(skid_addr),
		.o_data(skid_data), .o_sel(skid_sel), .i_stall(dec_stall));

	addrdecode #(.NS(NS), .SLAVE_ADDR(SLAVE_ADDR), .SLAVE_MASK(SLAVE_MASK),
		.OPT_REGISTERED(OPT_REGISTERED)) u_dec (.i_clk, .i_reset,
		.i_valid(skid_valid), .i_we(skid_we), .i_addr(skid_addr),
		.i_data(skid_data), .i_sel(skid_sel), .o_stall(dec_stall),
		.o_valid(dec_valid), .o_decode(dec_decode), .o_we(dec_we),
		.o_addr(dec_addr), .o_data(dec_data), .o_sel(dec_sel),
		.i_stall(rtr_stall));

	wb_slave_router #(.NS(NS)) u_rtr (.i_clk, .i_reset, .i_valid(dec_valid),
		.i_decode(dec_decode), .i_we(dec_we), .i_addr(dec_addr),
		.i_data(dec_data), .i_sel(dec_sel), .o_stall(rtr_stall),
		.o_slv_stb, .o_slv_we, .o_slv_addr, .o_slv_data, .o_slv_sel,
		.i_slv_ack, .i_slv_rdata, .o_ack, .o_err, .o_rdata);

endmodule

//--- wb_decode_assert.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Protocol checks on the router, bound into wb_slave_router
////////////////////////////////////////////////////////////
module wb_decode_assert
#(
	parameter int NS = 1
)
(
	input	logic			i_clk,
	input	logic			i_reset,
	input	wbdec_pkg::rtr_state_t	i_state,
	input	logic	[NS-1:0]	i_slv_stb,
	input	logic			i_ack,
	input	logic			i_err
);

	// Set by a strobe, cleared by the acknowledge to the master
	logic	owed;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			owed <= 1'b0;
		else if (i_slv_stb != '0)
			owed <= 1'b1;
		else if (i_ack)
			owed <= 1'b0;
	end

	// Never more than one slave strobed
	stb_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
		$onehot0(i_slv_stb))
		else $error("more than one slave strobe bit high");

	// A response is an acknowledge or an error, not both
	ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_ack && i_err))
		else $error("acknowledge and bus error high together");

	// Router sits in its wait state with no new strobe until the slave answers
	no_stb_in_wait: assert property (@(posedge i_clk) disable iff (i_reset)
		(owed && !i_ack) |-> ((i_state == wbdec_pkg::RTR_WAIT) && (i_slv_stb == '0)))
		else $error("slave strobe issued while waiting on an acknowledge");

endmodule

// Attached to every router instance
bind wb_slave_router wb_decode_assert #(.NS(NS)) u_assert
(
	.i_clk(i_clk),
	.i_reset(i_reset),
	.i_state(state),
	.i_slv_stb(o_slv_stb),
	.i_ack(o_ack),
	.i_err(o_err)
);

//--- tb_wb_decode.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Testbench for the decode subsystem, random master traffic
// against slave models, checked with an in-order model queue
////////////////////////////////////////////////////////////
module tb_wb_decode;

	localparam int NS = 4;
	localparam int STALL_LIMIT = 100;
	localparam int DRAIN_LIMIT = 400;
	localparam logic [NS-1:0] STB_LSB = {{(NS-1){1'b0}}, 1'b1};

	////////////////////////////////////////////////////////
	// Model slave map, base and mask per slave
	////////////////////////////////////////////////////////
	localparam wbdec_pkg::addr_t MAP_BASE [NS] =
		'{32'h0000_0000, 32'h1000_0000, 32'h4000_0000, 32'h8000_0000};
	localparam wbdec_pkg::addr_t MAP_MASK [NS] =
		'{32'hF000_0000, 32'hF000_0000, 32'hC000_0000, 32'hC000_0000};

	// One accepted request, slv is NS for no owner
	typedef struct packed
	{
		logic			we;
		wbdec_pkg::addr_t	addr;
		wbdec_pkg::data_t	data;
		wbdec_pkg::sel_t	sel;
		int			slv;
	} req_t;

	logic				i_clk;
	logic				i_reset;
	logic				i_stb;
	logic				i_we;
	wbdec_pkg::addr_t		i_addr;
	wbdec_pkg::data_t		i_data;
	wbdec_pkg::sel_t		i_sel;
	logic				o_stall;
	logic	[NS-1:0]		o_slv_stb;
	logic				o_slv_we;
	wbdec_pkg::addr_t		o_slv_addr;
	wbdec_pkg::data_t		o_slv_data;
	wbdec_pkg::sel_t		o_slv_sel;
	logic	[NS-1:0]		i_slv_ack;
	wbdec_pkg::data_t [NS-1:0]	i_slv_rdata;
	logic				o_ack;
	logic				o_err;
	wbdec_pkg::data_t		o_rdata;

	// Requests still owed a response, oldest first
	req_t		exp_q [$];
	// Oldest request has had its strobe
	logic		stb_seen;
	integer		seed;
	int		errors;
	int		accept_count;
	int		resp_count;
	int		ack_lo;
	int		ack_hi;
	bit		timeout_hit;

	wb_decode_top u_dut (.i_clk, .i_reset, .i_stb, .i_we, .i_addr, .i_data, .i_sel,
		.o_stall, .o_slv_stb, .o_slv_we, .o_slv_addr, .o_slv_data, .o_slv_sel,
		.i_slv_ack, .i_slv_rdata, .o_ack, .o_err, .o_rdata);

	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////
	// Model helpers
	////////////////////////////////////////////////////////

	// Owner of an address, NS when nobody owns it
	function automatic int expected_slave(input wbdec_pkg::addr_t addr);
		int slv;
		slv = NS;
		for (int i = NS - 1; i >= 0; i--)
			if ((addr & MAP_MASK[i]) == MAP_BASE[i])
				slv = i;
		return slv;
	endfunction

	// Read word a slave returns, from its index and the whole address
	function automatic wbdec_pkg::data_t slave_word(input int idx,
		input wbdec_pkg::addr_t addr);
		return {addr[15:0], addr[31:16]} ^ {8'(idx + 1), 24'h5AC396};
	endfunction

	task automatic show_mismatch(input string name, input string got, input string exp);
		$display("Mismatch at %0t ns: %s got %s expected %s", $time, name, got, exp);
		errors++;
	endtask

	task automatic flag_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	////////////////////////////////////////////////////////
	// Master driver, called 5 ns after a rising edge
	////////////////////////////////////////////////////////
	task automatic send_request(input int gap);
		int cycles;
		int region;
		logic [31:0] r;
		req_t req;
		repeat (gap)
		begin
			@(posedge i_clk);
			#5;
		end
		// Bias toward every region and both gaps in the map
		region = $unsigned($random(seed)) % 6;
		r = $random(seed);
		case (region)
			0: i_addr = {4'h0, r[27:0]};
			1: i_addr = {4'h1, r[27:0]};
			2: i_addr = {2'b01, r[29:0]};
			3: i_addr = {2'b10, r[29:0]};
			4: i_addr = {3'b001, r[28:0]};
			default: i_addr = {2'b11, r[29:0]};
		endcase
		i_we = 1'($random(seed));
		i_data = $random(seed);
		i_sel = wbdec_pkg::sel_t'($random(seed));
		i_stb = 1'b1;
		// Stall is registered, so it holds for the whole cycle
		cycles = 0;
		while (o_stall && (cycles < STALL_LIMIT))
		begin
			@(posedge i_clk);
			#5;
			cycles++;
		end
		assert (!o_stall)
		else
		begin
			flag_error("o_stall stayed high, request never accepted");
			timeout_hit = 1'b1;
		end
		if (!o_stall)
		begin
			req.we = i_we;
			req.addr = i_addr;
			req.data = i_data;
			req.sel = i_sel;
			req.slv = expected_slave(i_addr);
			exp_q.push_back(req);
			accept_count++;
		end
		@(posedge i_clk);
		#5;
		i_stb = 1'b0;
	endtask

	// Wait until every accepted request has been answered
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while ((resp_count != accept_count) && (cycles < DRAIN_LIMIT))
		begin
			@(posedge i_clk);
			#5;
			cycles++;
		end
		// A few idle cycles so a duplicate response would show up
		repeat (3)
		begin
			@(posedge i_clk);
			#5;
		end
		assert (resp_count == accept_count)
		else
		begin
			flag_error($sformatf("%0d responses for %0d accepted requests at drain timeout",
				resp_count, accept_count));
			timeout_hit = 1'b1;
		end
		assert (exp_q.size() == 0) else flag_error("requests left without a response");
	endtask

	////////////////////////////////////////////////////////
	// Output monitor, sampled at the falling edge
	////////////////////////////////////////////////////////
	task automatic verify_strobe();
		req_t req;
		logic [NS-1:0] exp_stb;
		if (exp_q.size() == 0)
			flag_error("slave strobe with no request pending");
		else
		begin
			req = exp_q[0];
			exp_stb = STB_LSB << req.slv;
			assert (!stb_seen) else flag_error("second slave strobe for one request");
			assert (req.slv != NS) else flag_error("slave strobed for an unmapped address");
			assert (o_slv_stb == exp_stb)
			else show_mismatch("o_slv_stb", $sformatf("%b", o_slv_stb),
				$sformatf("%b", exp_stb));
			assert (o_slv_addr == req.addr)
			else show_mismatch("o_slv_addr", $sformatf("%h", o_slv_addr),
				$sformatf("%h", req.addr));
			assert (o_slv_we == req.we)
			else show_mismatch("o_slv_we", $sformatf("%b", o_slv_we), $sformatf("%b", req.we));
			assert (o_slv_data == req.data)
			else show_mismatch("o_slv_data", $sformatf("%h", o_slv_data),
				$sformatf("%h", req.data));
			assert (o_slv_sel == req.sel)
			else show_mismatch("o_slv_sel", $sformatf("%b", o_slv_sel),
				$sformatf("%b", req.sel));
			stb_seen = 1'b1;
		end
	endtask

	task automatic match_response();
		req_t req;
		wbdec_pkg::data_t exp_word;
		if (exp_q.size() == 0)
			flag_error("response with no request pending");
		else
		begin
			req = exp_q.pop_front();
			resp_count++;
			if (req.slv == NS)
			begin
				assert (o_err && !o_ack)
				else flag_error($sformatf("unmapped address %h not answered by o_err alone",
					req.addr));
				assert (!stb_seen) else flag_error("unmapped request reached a slave");
			end
			else
			begin
				assert (o_ack && !o_err)
				else flag_error($sformatf("mapped address %h not answered by o_ack alone",
					req.addr));
				assert (stb_seen) else flag_error("o_ack without a slave strobe");
				exp_word = slave_word(req.slv, req.addr);
				if (!req.we)
					assert (o_rdata == exp_word)
					else show_mismatch("o_rdata", $sformatf("%h", o_rdata),
						$sformatf("%h", exp_word));
			end
			stb_seen = 1'b0;
		end
	endtask

	always @(negedge i_clk)
	begin
		if (!i_reset && (o_slv_stb != '0))
			verify_strobe();
		if (!i_reset && (o_ack || o_err))
			match_response();
	end

	////////////////////////////////////////////////////////
	// Slave models, only the strobed slave answers
	////////////////////////////////////////////////////////
	initial
	begin : slave_model
		int idx;
		int ack_delay;
		wbdec_pkg::data_t word;
		forever
		begin
			@(negedge i_clk);
			if (!i_reset && (o_slv_stb != '0))
			begin
				idx = 0;
				for (int k = 0; k < NS; k++)
					if (o_slv_stb == (STB_LSB << k))
						idx = k;
				word = slave_word(idx, o_slv_addr);
				ack_delay = ack_lo + $unsigned($random(seed)) % (ack_hi - ack_lo + 1);
				repeat (ack_delay) @(posedge i_clk);
				@(posedge i_clk);
				#5;
				// Other lanes carry the inverse to catch a wrong select
				for (int k = 0; k < NS; k++)
					i_slv_rdata[k] = (k == idx) ? word : ~word;
				i_slv_ack = STB_LSB << idx;
				@(posedge i_clk);
				#5;
				i_slv_ack = '0;
			end
		end
	end

	////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////
	initial
	begin : main
		int err_start;
		seed = 32'h81cc0bcc;
		errors = 0;
		accept_count = 0;
		resp_count = 0;
		timeout_hit = 1'b0;
		stb_seen = 1'b0;
		ack_lo = 0;
		ack_hi = 5;
		i_reset = 1'b1;
		i_stb = 1'b0;
		i_we = 1'b0;
		i_addr = '0;
		i_data = '0;
		i_sel = '0;
		i_slv_ack = '0;
		i_slv_rdata = '0;
		repeat (3) @(posedge i_clk);
		#5;
		i_reset = 1'b0;

		// Idle outputs after reset, nothing strobed yet
		err_start = errors;
		repeat (4)
		begin
			@(negedge i_clk);
			assert (!o_stall) else show_mismatch("o_stall", "1", "0");
			assert (!o_ack) else show_mismatch("o_ack", "1", "0");
			assert (!o_err) else show_mismatch("o_err", "1", "0");
			assert (o_slv_stb == '0)
			else show_mismatch("o_slv_stb", $sformatf("%b", o_slv_stb), "0000");
		end
		$display("test 1 reset state: %0d errors", errors - err_start);
		@(posedge i_clk);
		#5;

		// Mixed mapped and unmapped traffic with random gaps
		err_start = errors;
		for (int n = 0; n < 80; n++)
			if (!timeout_hit)
				send_request($unsigned($random(seed)) % 4);
		wait_drain();
		$display("test 2 random routing: %0d errors", errors - err_start);

		// Back-to-back burst against slow acknowledges
		err_start = errors;
		ack_lo = 3;
		for (int n = 0; n < 32; n++)
			if (!timeout_hit)
				send_request(0);
		if (!timeout_hit)
			wait_drain();
		$display("test 3 back-pressure burst: %0d errors", errors - err_start);

		$display("tests 3, requests %0d, responses %0d, errors %0d",
			accept_count, resp_count, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- flist.f
wbdec_pkg.sv
wb_skid.sv
addrdecode.sv
wb_slave_router.sv
wb_decode_top.sv
wb_decode_assert.sv
tb_wb_decode.sv

//--- Makefile
# Verilator build and run of the decode subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_decode
FLIST     ?= flist.f
MDIR      ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= RESULT: PASS
VFLAGS    ?= --binary --assert

SRCS := $(shell cat $(FLIST))
BIN  := $(MDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FLIST)

# Pass or fail comes from the log, not the exit status
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
